//--- dac_tx.f
verilog/dac_tx_pkg.sv
verilog/dac_tx_regs.sv
verilog/dac_tx_tone_gen.sv
verilog/dac_tx_dma_path.sv
verilog/dac_tx_sample_sel.sv
verilog/dac_tx_top.sv
verif/dac_tx_clk_gen.sv
verif/dac_tx_tb.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the dac_tx testbench with verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module dac_tx_tb -f dac_tx.f -o dac_tx_sim
./obj_dir/dac_tx_sim 2>&1 | tee sim.log
if grep -q "Result: FAILED" sim.log; then
  echo "simulation reported a failure"
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without a result"
  exit 1
fi
echo "simulation passed"

//--- verif/dac_tx_clk_gen.sv
// ***********************************************************
// dac transmit testbench clock source
// free running 8 ns clock for dac_div_clk
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module dac_tx_clk_gen (
  output logic clk
);

  initial clk = 1'b0;

  // half period of 4 ns
  always #4 clk = ~clk;

endmodule

`default_nettype wire

//--- verif/dac_tx_tb.sv
// ***********************************************************
// dac transmit data path testbench
// directed tests for the up bus, dma stream, tone source,
// pattern and format, and the sticky status flags
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module dac_tx_tb import dac_tx_pkg::*; ();

  logic                 clk;
  logic                 rst;
  logic                 up_wreq;
  logic [UP_ADDR_W-1:0] up_waddr;
  logic [31:0]          up_wdata;
  logic                 up_wack;
  logic                 up_rreq;
  logic [UP_ADDR_W-1:0] up_raddr;
  logic [31:0]          up_rdata;
  logic                 up_rack;
  logic                 dac_valid;
  logic                 dac_enable;
  logic [DDATA_W-1:0]   dac_ddata;
  logic                 dac_dunf;
  logic                 dac_dovf;
  logic [SAMPLE_W-1:0]  dac_data_0;
  logic [SAMPLE_W-1:0]  dac_data_1;
  logic [SAMPLE_W-1:0]  dac_data_2;
  logic [SAMPLE_W-1:0]  dac_data_3;
  logic [31:0]          lfsr_state;
  int                   cycle_count = 0;

  dac_tx_clk_gen clk_gen0 (.clk(clk));

  dac_tx_top dut0 (
    .dac_div_clk (clk),        .rst        (rst),
    .up_wreq     (up_wreq),    .up_waddr   (up_waddr),
    .up_wdata    (up_wdata),   .up_wack    (up_wack),
    .up_rreq     (up_rreq),    .up_raddr   (up_raddr),
    .up_rdata    (up_rdata),   .up_rack    (up_rack),
    .dac_valid   (dac_valid),  .dac_enable (dac_enable),
    .dac_ddata   (dac_ddata),  .dac_dunf   (dac_dunf),
    .dac_dovf    (dac_dovf),   .dac_data_0 (dac_data_0),
    .dac_data_1  (dac_data_1), .dac_data_2 (dac_data_2),
    .dac_data_3  (dac_data_3));

  // ***********************************************************
  // helpers
  // ***********************************************************
  task automatic abort_run(input string msg);
    $display("FAILED at %0t ns: %s", $time, msg);
    $display("Result: FAILED");
    $fatal(1, "stopped at first error");
  endtask

  // inputs change and outputs are sampled on the falling edge
  task automatic tick();
    @(negedge clk);
  endtask

  // x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw_word(output logic [DDATA_W-1:0] w);
    w = '0;
    for (int b = 0; b < DDATA_W; b++) begin
      lfsr_state = lfsr_next(lfsr_state);
      w = {w[DDATA_W-2:0], lfsr_state[0]};
    end
  endtask

  function automatic logic [31:0] control_word(input logic en, input logic [1:0] src,
                                               input logic ob);
    return {28'd0, ob, src, en};
  endfunction

  // signed triangle rising below phase 0x8000 and falling above
  function automatic logic [SAMPLE_W-1:0] triangle_ref(input logic [PHASE_W-1:0] p);
    int v;
    int s;
    v = {16'd0, p};
    if (v < 32768)
      s = 2 * v - 32768;
    else
      s = 32767 - 2 * (v - 32768);
    return s[SAMPLE_W-1:0];
  endfunction

  task automatic write_reg(input logic [UP_ADDR_W-1:0] addr, input logic [31:0] data);
    up_wreq  = 1'b1;
    up_waddr = addr;
    up_wdata = data;
    tick();
    assert (up_wack === 1'b1)
      else abort_run($sformatf("write ack missing one cycle after strobe, addr %h", addr));
    up_wreq  = 1'b0;
    up_waddr = '0;
    up_wdata = '0;
  endtask

  task automatic expect_read(input logic [UP_ADDR_W-1:0] addr, input logic [31:0] exp);
    up_rreq  = 1'b1;
    up_raddr = addr;
    tick();
    assert (up_rack === 1'b1)
      else abort_run($sformatf("read ack missing one cycle after strobe, addr %h", addr));
    assert (up_rdata === exp)
      else abort_run($sformatf("read addr %h got %h expected %h", addr, up_rdata, exp));
    up_rreq  = 1'b0;
    up_raddr = '0;
  endtask

  task automatic check_lanes(input logic [SAMPLE_W-1:0] e0, input logic [SAMPLE_W-1:0] e1,
                             input logic [SAMPLE_W-1:0] e2, input logic [SAMPLE_W-1:0] e3,
                             input string what);
    assert (dac_data_0 === e0)
      else abort_run($sformatf("%s lane 0 got %h expected %h", what, dac_data_0, e0));
    assert (dac_data_1 === e1)
      else abort_run($sformatf("%s lane 1 got %h expected %h", what, dac_data_1, e1));
    assert (dac_data_2 === e2)
      else abort_run($sformatf("%s lane 2 got %h expected %h", what, dac_data_2, e2));
    assert (dac_data_3 === e3)
      else abort_run($sformatf("%s lane 3 got %h expected %h", what, dac_data_3, e3));
  endtask

  task automatic expect_idle(input string what);
    assert (dac_valid === 1'b0 && dac_enable === 1'b0)
      else abort_run($sformatf("%s valid/enable not low", what));
    check_lanes('0, '0, '0, '0, what);
  endtask

  // ***********************************************************
  // directed tests
  // ***********************************************************
  task automatic idle_state();
    assert (up_wack === 1'b0 && up_rack === 1'b0)
      else abort_run("bus ack high after reset");
    repeat (4) begin
      expect_idle("after reset");
      tick();
    end
    // source chosen but not enabled so lanes stay quiet
    write_reg(REG_PATTERN, 32'h0000_1234);
    write_reg(REG_CONTROL, control_word(1'b0, SRC_PATTERN, 1'b1));
    repeat (6) begin
      expect_idle("disabled");
      tick();
    end
    write_reg(REG_CONTROL, 32'd0);
    tick();
  endtask

  task automatic register_access();
    expect_read(REG_VERSION, CORE_VERSION);
    tick();
    assert (up_rack === 1'b0 && up_rdata === 32'd0)
      else abort_run("read ack or data held past one cycle");
    write_reg(REG_SCRATCH, 32'ha5c3_0f96);
    tick();
    assert (up_wack === 1'b0) else abort_run("write ack held past one cycle");
    expect_read(REG_SCRATCH, 32'ha5c3_0f96);
    write_reg(14'h0123, 32'hffff_ffff);
    expect_read(14'h0123, 32'd0);
    expect_read(REG_SCRATCH, 32'ha5c3_0f96);
    tick();
  endtask

  task automatic dma_stream();
    logic [DDATA_W-1:0] words [32];
    logic [DDATA_W-1:0] w;
    write_reg(REG_CONTROL, control_word(1'b1, SRC_DMA, 1'b0));
    for (int i = 0; i < 34; i++) begin
      assert (dac_valid === 1'b1 && dac_enable === 1'b1)
        else abort_run("dac_valid or dac_enable low while enabled");
      if (i >= 2)
        check_lanes(words[i-2][15:0], words[i-2][31:16], words[i-2][47:32],
                    words[i-2][63:48], "dma");
      else
        check_lanes('0, '0, '0, '0, "dma fill");
      if (i < 32) begin
        draw_word(w);
        words[i] = w;
        dac_ddata = w;
      end else begin
        dac_ddata = '0;
      end
      tick();
    end
    write_reg(REG_CONTROL, 32'd0);
    tick();
  endtask

  task automatic tone_generation();
    logic [PHASE_W-1:0]  incr;
    logic [PHASE_W-1:0]  ph;
    logic [SAMPLE_W-1:0] exp_lane [4];
    incr = 16'h0d35;
    write_reg(REG_TONE_INCR, {16'd0, incr});
    write_reg(REG_CONTROL, control_word(1'b1, SRC_TONE, 1'b0));
    repeat (2) begin
      check_lanes('0, '0, '0, '0, "tone start");
      tick();
    end
    // model phase of lane 0 starts at zero
    ph = '0;
    repeat (40) begin
      for (int k = 0; k < 4; k++) begin
        exp_lane[k] = triangle_ref(ph);
        ph = ph + incr;
      end
      check_lanes(exp_lane[0], exp_lane[1], exp_lane[2], exp_lane[3], "tone");
      tick();
    end
    write_reg(REG_CONTROL, 32'd0);
    tick();
  endtask

  task automatic pattern_and_format();
    logic [SAMPLE_W-1:0] pat;
    logic [SAMPLE_W-1:0] obin;
    pat  = 16'h3c96;
    obin = {~pat[15], pat[14:0]};
    write_reg(REG_PATTERN, {16'd0, pat});
    write_reg(REG_CONTROL, control_word(1'b1, SRC_PATTERN, 1'b0));
    tick();
    tick();
    repeat (6) begin
      check_lanes(pat, pat, pat, pat, "pattern");
      tick();
    end
    write_reg(REG_CONTROL, control_word(1'b1, SRC_PATTERN, 1'b1));
    repeat (2) begin
      check_lanes(pat, pat, pat, pat, "pattern before format change");
      tick();
    end
    repeat (6) begin
      check_lanes(obin, obin, obin, obin, "offset binary");
      tick();
    end
    write_reg(REG_CONTROL, 32'd0);
    tick();
  endtask

  task automatic pulse_flags(input logic unf, input logic ovf);
    dac_dunf = unf;
    dac_dovf = ovf;
    tick();
    dac_dunf = 1'b0;
    dac_dovf = 1'b0;
    tick();
    tick();
  endtask

  task automatic sticky_flags();
    expect_read(REG_STATUS, 32'd0);
    pulse_flags(1'b1, 1'b1);
    expect_read(REG_STATUS, 32'd0);
    write_reg(REG_CONTROL, control_word(1'b1, SRC_ZERO, 1'b0));
    pulse_flags(1'b1, 1'b0);
    expect_read(REG_STATUS, 32'd1);
    pulse_flags(1'b0, 1'b1);
    expect_read(REG_STATUS, 32'd3);
    write_reg(REG_CONTROL, 32'd0);
    // write one to clear
    write_reg(REG_STATUS, 32'd1);
    expect_read(REG_STATUS, 32'd2);
    write_reg(REG_STATUS, 32'd2);
    expect_read(REG_STATUS, 32'd0);
    tick();
  endtask

  // ***********************************************************
  // run control
  // ***********************************************************
  always @(posedge clk) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= 2000) begin
      $display("timeout: tests did not finish within 2000 cycles");
      $display("Result: FAILED");
      $fatal(1, "timeout");
    end
  end

  initial begin
    rst        = 1'b1;
    up_wreq    = 1'b0;
    up_waddr   = '0;
    up_wdata   = '0;
    up_rreq    = 1'b0;
    up_raddr   = '0;
    dac_ddata  = '0;
    dac_dunf   = 1'b0;
    dac_dovf   = 1'b0;
    lfsr_state = 32'h1d57_3839;
    repeat (16) @(negedge clk);
    rst = 1'b0;
    idle_state();
    register_access();
    dma_stream();
    tone_generation();
    pattern_and_format();
    sticky_flags();
    $display("Result: PASSED");
    $finish;
  end

endmodule

`default_nettype wire

//--- verilog/dac_tx_dma_path.sv
// ***********************************************************
// dac transmit dma path
// requests a word every enabled cycle, splits it into lanes
// and reports qualified underflow/overflow events
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module dac_tx_dma_path import dac_tx_pkg::*; (
  input  logic                dac_div_clk,
  input  logic                rst,
  input  logic                enable,
  output logic                dac_valid,
  input  logic [DDATA_W-1:0]  dac_ddata,
  input  logic                dac_dunf,
  input  logic                dac_dovf,
  output logic [SAMPLE_W-1:0] dma_0,
  output logic [SAMPLE_W-1:0] dma_1,
  output logic [SAMPLE_W-1:0] dma_2,
  output logic [SAMPLE_W-1:0] dma_3,
  output logic                dma_unf,
  output logic                dma_ovf
);

  logic [SAMPLE_W-1:0] lane_q [NUM_LANES];

  // no back-pressure, a word is taken every enabled cycle
  assign dac_valid = enable;

  // lane k from bits 16k+15:16k
  always_ff @(posedge dac_div_clk) begin
    if (dac_valid) begin
      for (int k = 0; k < NUM_LANES; k++) begin
        lane_q[k] <= dac_ddata[k*SAMPLE_W +: SAMPLE_W];
      end
    end
  end

  // source flags only count when a word was consumed
  always_ff @(posedge dac_div_clk) begin
    if (rst) begin
      dma_unf <= 1'b0;
      dma_ovf <= 1'b0;
    end else begin
      dma_unf <= dac_valid & dac_dunf;
      dma_ovf <= dac_valid & dac_dovf;
    end
  end

  assign dma_0 = lane_q[0];
  assign dma_1 = lane_q[1];
  assign dma_2 = lane_q[2];
  assign dma_3 = lane_q[3];

endmodule

`default_nettype wire

//--- verilog/dac_tx_pkg.sv
// ***********************************************************
// dac transmit data path shared definitions
// lane geometry, register map, source codes and version
// ***********************************************************

`default_nettype none

package dac_tx_pkg;

  // data path geometry
  localparam int NUM_LANES = 4;
  localparam int SAMPLE_W  = 16;
  localparam int DDATA_W   = 64;
  localparam int PHASE_W   = 16;
  localparam int UP_ADDR_W = 14;

  // ***********************************************************
  // register map, word addresses
  // ***********************************************************
  localparam logic [UP_ADDR_W-1:0] REG_VERSION   = 14'h00;
  localparam logic [UP_ADDR_W-1:0] REG_SCRATCH   = 14'h01;
  localparam logic [UP_ADDR_W-1:0] REG_CONTROL   = 14'h02;
  localparam logic [UP_ADDR_W-1:0] REG_TONE_INCR = 14'h03;
  localparam logic [UP_ADDR_W-1:0] REG_PATTERN   = 14'h04;
  localparam logic [UP_ADDR_W-1:0] REG_STATUS    = 14'h05;

  // major.minor.patch as 16.8.8
  localparam logic [31:0] CORE_VERSION = 32'h0001_0100;

  // sample source select codes
  localparam logic [1:0] SRC_ZERO    = 2'd0;
  localparam logic [1:0] SRC_TONE    = 2'd1;
  localparam logic [1:0] SRC_DMA     = 2'd2;
  localparam logic [1:0] SRC_PATTERN = 2'd3;

endpackage

`default_nettype wire

//--- verilog/dac_tx_regs.sv
// ***********************************************************
// dac transmit processor register bank
// up bus write/read strobes with one cycle acks, config
// outputs and sticky underflow/overflow status
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module dac_tx_regs import dac_tx_pkg::*; (
  input  logic                 dac_div_clk,
  input  logic                 rst,

  // up bus
  input  logic                 up_wreq,
  input  logic [UP_ADDR_W-1:0] up_waddr,
  input  logic [31:0]          up_wdata,
  output logic                 up_wack,
  input  logic                 up_rreq,
  input  logic [UP_ADDR_W-1:0] up_raddr,
  output logic [31:0]          up_rdata,
  output logic                 up_rack,

  // events from the dma path
  input  logic                 dma_unf,
  input  logic                 dma_ovf,

  // configuration
  output logic                 enable,
  output logic [1:0]           src_sel,
  output logic                 offset_bin,
  output logic [PHASE_W-1:0]   tone_incr,
  output logic [SAMPLE_W-1:0]  pattern
);

  logic [31:0] scratch;
  logic        unf_sticky;
  logic        ovf_sticky;
  logic        status_clr_unf;
  logic        status_clr_ovf;

  assign status_clr_unf = up_wreq && (up_waddr == REG_STATUS) && up_wdata[0];
  assign status_clr_ovf = up_wreq && (up_waddr == REG_STATUS) && up_wdata[1];

  // ***********************************************************
  // write side
  // ***********************************************************
  always_ff @(posedge dac_div_clk) begin
    if (rst) begin
      up_wack    <= 1'b0;
      scratch    <= '0;
      enable     <= 1'b0;
      src_sel    <= SRC_ZERO;
      offset_bin <= 1'b0;
      tone_incr  <= '0;
      pattern    <= '0;
    end else begin
      up_wack <= up_wreq;
      if (up_wreq) begin
        case (up_waddr)
          REG_SCRATCH: scratch <= up_wdata;
          REG_CONTROL: begin
            enable     <= up_wdata[0];
            src_sel    <= up_wdata[2:1];
            offset_bin <= up_wdata[3];
          end
          REG_TONE_INCR: tone_incr <= up_wdata[PHASE_W-1:0];
          REG_PATTERN:   pattern   <= up_wdata[SAMPLE_W-1:0];
          default: ;
        endcase
      end
    end
  end

  // sticky flags, a new event wins over a clear
  always_ff @(posedge dac_div_clk) begin
    if (rst) begin
      unf_sticky <= 1'b0;
      ovf_sticky <= 1'b0;
    end else begin
      unf_sticky <= dma_unf | (unf_sticky & ~status_clr_unf);
      ovf_sticky <= dma_ovf | (ovf_sticky & ~status_clr_ovf);
    end
  end

  // ***********************************************************
  // read side, data only valid with the ack
  // ***********************************************************
  always_ff @(posedge dac_div_clk) begin
    if (rst) begin
      up_rack  <= 1'b0;
      up_rdata <= '0;
    end else begin
      up_rack  <= up_rreq;
      up_rdata <= '0;
      if (up_rreq) begin
        case (up_raddr)
          REG_VERSION:   up_rdata <= CORE_VERSION;
          REG_SCRATCH:   up_rdata <= scratch;
          REG_CONTROL:   up_rdata <= {28'd0, offset_bin, src_sel, enable};
          REG_TONE_INCR: up_rdata <= {{(32-PHASE_W){1'b0}}, tone_incr};
          REG_PATTERN:   up_rdata <= {{(32-SAMPLE_W){1'b0}}, pattern};
          REG_STATUS:    up_rdata <= {30'd0, ovf_sticky, unf_sticky};
          default:       up_rdata <= '0;
        endcase
      end
    end
  end

endmodule

`default_nettype wire

//--- verilog/dac_tx_sample_sel.sv
// ***********************************************************
// dac transmit sample selector
// per lane source mux, offset binary option, output register
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module dac_tx_sample_sel import dac_tx_pkg::*; (
  input  logic                dac_div_clk,
  input  logic                rst,
  input  logic                enable,
  input  logic [1:0]          src_sel,
  input  logic                offset_bin,
  input  logic [SAMPLE_W-1:0] pattern,
  input  logic [SAMPLE_W-1:0] tone_0,
  input  logic [SAMPLE_W-1:0] tone_1,
  input  logic [SAMPLE_W-1:0] tone_2,
  input  logic [SAMPLE_W-1:0] tone_3,
  input  logic [SAMPLE_W-1:0] dma_0,
  input  logic [SAMPLE_W-1:0] dma_1,
  input  logic [SAMPLE_W-1:0] dma_2,
  input  logic [SAMPLE_W-1:0] dma_3,
  output logic [SAMPLE_W-1:0] dac_data_0,
  output logic [SAMPLE_W-1:0] dac_data_1,
  output logic [SAMPLE_W-1:0] dac_data_2,
  output logic [SAMPLE_W-1:0] dac_data_3
);

  logic                enable_q;
  logic [1:0]          src_sel_q;
  logic                offset_bin_q;
  logic [SAMPLE_W-1:0] pattern_q;
  logic [SAMPLE_W-1:0] tone_in [NUM_LANES];
  logic [SAMPLE_W-1:0] dma_in [NUM_LANES];
  logic [SAMPLE_W-1:0] sel_d [NUM_LANES];
  logic [SAMPLE_W-1:0] data_q [NUM_LANES];

  assign tone_in[0] = tone_0;
  assign tone_in[1] = tone_1;
  assign tone_in[2] = tone_2;
  assign tone_in[3] = tone_3;
  assign dma_in[0]  = dma_0;
  assign dma_in[1]  = dma_1;
  assign dma_in[2]  = dma_2;
  assign dma_in[3]  = dma_3;

  // config staged once so it lines up with the registered sources
  always_ff @(posedge dac_div_clk) begin
    if (rst) begin
      enable_q     <= 1'b0;
      src_sel_q    <= SRC_ZERO;
      offset_bin_q <= 1'b0;
    end else begin
      enable_q     <= enable;
      src_sel_q    <= src_sel;
      offset_bin_q <= offset_bin;
    end
  end

  always_ff @(posedge dac_div_clk) begin
    pattern_q <= pattern;
  end

  always_comb begin
    for (int k = 0; k < NUM_LANES; k++) begin
      case (src_sel_q)
        SRC_TONE:    sel_d[k] = tone_in[k];
        SRC_DMA:     sel_d[k] = dma_in[k];
        SRC_PATTERN: sel_d[k] = pattern_q;
        default:     sel_d[k] = '0;
      endcase
      // two's complement to offset binary
      if (offset_bin_q) begin
        sel_d[k][SAMPLE_W-1] = ~sel_d[k][SAMPLE_W-1];
      end
    end
  end

  // ***********************************************************
  // output register, zero while disabled
  // ***********************************************************
  always_ff @(posedge dac_div_clk) begin
    for (int k = 0; k < NUM_LANES; k++) begin
      if (rst || !enable_q) begin
        data_q[k] <= '0;
      end else begin
        data_q[k] <= sel_d[k];
      end
    end
  end

  assign dac_data_0 = data_q[0];
  assign dac_data_1 = data_q[1];
  assign dac_data_2 = data_q[2];
  assign dac_data_3 = data_q[3];

endmodule

`default_nettype wire

//--- verilog/dac_tx_tone_gen.sv
// ***********************************************************
// dac transmit tone generator
// phase accumulator with four lane phases per clock, each
// folded into a signed triangle sample
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module dac_tx_tone_gen import dac_tx_pkg::*; (
  input  logic                dac_div_clk,
  input  logic                rst,
  input  logic                enable,
  input  logic [PHASE_W-1:0]  tone_incr,
  output logic [SAMPLE_W-1:0] tone_0,
  output logic [SAMPLE_W-1:0] tone_1,
  output logic [SAMPLE_W-1:0] tone_2,
  output logic [SAMPLE_W-1:0] tone_3
);

  logic [PHASE_W-1:0]  acc;
  logic [PHASE_W-1:0]  lane_phase [NUM_LANES];
  logic [PHASE_W-1:0]  acc_next;
  logic [SAMPLE_W-1:0] lane_q [NUM_LANES];

  // rising half maps 0..7fff to -32768..32766,
  // falling half mirrors it back down
  function automatic logic [SAMPLE_W-1:0] triangle(input logic [PHASE_W-1:0] p);
    logic [SAMPLE_W-1:0] dbl;
    begin
      dbl = {p[PHASE_W-2:0], 1'b0};
      if (!p[PHASE_W-1])
        triangle = dbl - 16'h8000;
      else
        triangle = 16'h7fff - dbl;
    end
  endfunction

  // lane k sits k increments past the accumulator
  always_comb begin
    lane_phase[0] = acc;
    for (int k = 1; k < NUM_LANES; k++) begin
      lane_phase[k] = lane_phase[k-1] + tone_incr;
    end
    acc_next = lane_phase[NUM_LANES-1] + tone_incr;
  end

  // accumulator held at zero while disabled
  always_ff @(posedge dac_div_clk) begin
    if (rst) begin
      acc <= '0;
    end else if (enable) begin
      acc <= acc_next;
    end else begin
      acc <= '0;
    end
  end

  always_ff @(posedge dac_div_clk) begin
    for (int k = 0; k < NUM_LANES; k++) begin
      lane_q[k] <= triangle(lane_phase[k]);
    end
  end

  assign tone_0 = lane_q[0];
  assign tone_1 = lane_q[1];
  assign tone_2 = lane_q[2];
  assign tone_3 = lane_q[3];

endmodule

`default_nettype wire

//--- verilog/dac_tx_top.sv
// ***********************************************************
// dac transmit data path top level
// register bank, tone and dma sources, sample selector
// ***********************************************************

`timescale 1ns/1ps
`default_nettype none

module dac_tx_top import dac_tx_pkg::*; (
  input  logic                 dac_div_clk,
  input  logic                 rst,

  // up bus
  input  logic                 up_wreq,
  input  logic [UP_ADDR_W-1:0] up_waddr,
  input  logic [31:0]          up_wdata,
  output logic                 up_wack,
  input  logic                 up_rreq,
  input  logic [UP_ADDR_W-1:0] up_raddr,
  output logic [31:0]          up_rdata,
  output logic                 up_rack,

  // dma stream
  output logic                 dac_valid,
  output logic                 dac_enable,
  input  logic [DDATA_W-1:0]   dac_ddata,
  input  logic                 dac_dunf,
  input  logic                 dac_dovf,

  // sample lanes to the serializer
  output logic [SAMPLE_W-1:0]  dac_data_0,
  output logic [SAMPLE_W-1:0]  dac_data_1,
  output logic [SAMPLE_W-1:0]  dac_data_2,
  output logic [SAMPLE_W-1:0]  dac_data_3
);

  logic [1:0]          src_sel_s;
  logic                offset_bin_s;
  logic [PHASE_W-1:0]  tone_incr_s;
  logic [SAMPLE_W-1:0] pattern_s;
  logic                dma_unf_s;
  logic                dma_ovf_s;
  logic [SAMPLE_W-1:0] tone_s [NUM_LANES];
  logic [SAMPLE_W-1:0] dma_s [NUM_LANES];

  dac_tx_regs i_regs (
    .dac_div_clk (dac_div_clk),
    .rst         (rst),
    .up_wreq     (up_wreq),
    .up_waddr    (up_waddr),
    .up_wdata    (up_wdata),
    .up_wack     (up_wack),
    .up_rreq     (up_rreq),
    .up_raddr    (up_raddr),
    .up_rdata    (up_rdata),
    .up_rack     (up_rack),
    .dma_unf     (dma_unf_s),
    .dma_ovf     (dma_ovf_s),
    .enable      (dac_enable),
    .src_sel     (src_sel_s),
    .offset_bin  (offset_bin_s),
    .tone_incr   (tone_incr_s),
    .pattern     (pattern_s));

  dac_tx_tone_gen i_tone (
    .dac_div_clk (dac_div_clk),
    .rst         (rst),
    .enable      (dac_enable),
    .tone_incr   (tone_incr_s),
    .tone_0      (tone_s[0]),
    .tone_1      (tone_s[1]),
    .tone_2      (tone_s[2]),
    .tone_3      (tone_s[3]));

  dac_tx_dma_path i_dma (
    .dac_div_clk (dac_div_clk),
    .rst         (rst),
    .enable      (dac_enable),
    .dac_valid   (dac_valid),
    .dac_ddata   (dac_ddata),
    .dac_dunf    (dac_dunf),
    .dac_dovf    (dac_dovf),
    .dma_0       (dma_s[0]),
    .dma_1       (dma_s[1]),
    .dma_2       (dma_s[2]),
    .dma_3       (dma_s[3]),
    .dma_unf     (dma_unf_s),
    .dma_ovf     (dma_ovf_s));

  dac_tx_sample_sel i_sel (
    .dac_div_clk (dac_div_clk),
    .rst         (rst),
    .enable      (dac_enable),
    .src_sel     (src_sel_s),
    .offset_bin  (offset_bin_s),
    .pattern     (pattern_s),
    .tone_0      (tone_s[0]),
    .tone_1      (tone_s[1]),
    .tone_2      (tone_s[2]),
    .tone_3      (tone_s[3]),
    .dma_0       (dma_s[0]),
    .dma_1       (dma_s[1]),
    .dma_2       (dma_s[2]),
    .dma_3       (dma_s[3]),
    .dac_data_0  (dac_data_0),
    .dac_data_1  (dac_data_1),
    .dac_data_2  (dac_data_2),
    .dac_data_3  (dac_data_3));

endmodule

`default_nettype wire
